// File: verilog.f
+incdir+rtl
rtl/cp0_pkg.sv
rtl/cp0_commit.sv
rtl/cp0_status.sv
rtl/cp0_cause.sv
rtl/cp0_timer.sv
rtl/cp0_fault_addr.sv
rtl/cp0.sv
verif/cp0_props.sv
verif/tb_cp0.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cp0 testbench with verilator
LOG=sim.log

verilator --binary --assert --top-module tb_cp0 -f verilog.f > "$LOG" 2>&1 \
    && ./obj_dir/Vtb_cp0 >> "$LOG" 2>&1 \
    || echo "** FAIL **" >> "$LOG"

cat "$LOG"
grep -qF "** FAIL **" "$LOG" && exit 1 || exit 0

// File: verif/tb_cp0.sv
`include "cp0_cfg.svh"

module tb_cp0;

    localparam int TIMEOUT = 40;

    logic               clk, rst, valid, exception, bd, mtc0, eret, redirect;
    cp0_pkg::exc_code_t exc_code;
    cp0_pkg::cp0_addr_t cp0_addr;
    cp0_pkg::word_t     pc, bad_vaddr, wdata, cp0_res, lcg_state, trap_pc;
    cp0_pkg::hw_int_t   ext_int;
    string              test_name;
    int                 test_errs, tests_passed, tests_failed;

    cp0 i_cp0 (
        .clk(clk), .rst(rst), .valid(valid), .exception(exception), .bd(bd),
        .mtc0(mtc0), .eret(eret), .exc_code(exc_code), .cp0_addr(cp0_addr),
        .pc(pc), .bad_vaddr(bad_vaddr), .wdata(wdata), .ext_int(ext_int),
        .redirect(redirect), .cp0_res(cp0_res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------

    function automatic cp0_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // cause word as its fields should read back
    function automatic cp0_pkg::word_t cause_word(input logic bd_f, input logic ti,
                                                  input cp0_pkg::int_mask_t ip,
                                                  input cp0_pkg::exc_code_t code);
        return {bd_f, ti, 14'd0, ip, 1'b0, code, 2'b00};
    endfunction

    // ext_int left alone, tests hold it themselves
    task automatic drive_idle();
        {valid, exception, bd, mtc0, eret} = 5'b0;
        exc_code  = '0;
        cp0_addr  = '0;
        pc        = '0;
        bad_vaddr = '0;
        wdata     = '0;
    endtask

    // inputs change just after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input cp0_pkg::word_t got,
                              input cp0_pkg::word_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: %s got 0x%08h expected 0x%08h", test_name, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic write_reg(input cp0_pkg::cp0_addr_t addr, input cp0_pkg::word_t data);
        valid    = 1'b1;
        mtc0     = 1'b1;
        cp0_addr = addr;
        wdata    = data;
        step();
        drive_idle();
    endtask

    // mfc0 style, no strobes, sampled mid-cycle
    task automatic read_reg(input cp0_pkg::cp0_addr_t addr, output cp0_pkg::word_t data);
        cp0_addr = addr;
        @(negedge clk);
        data = cp0_res;
        step();
        drive_idle();
    endtask

    task automatic check_reg(input string name, input cp0_pkg::cp0_addr_t addr,
                             input cp0_pkg::word_t exp);
        cp0_pkg::word_t got;
        read_reg(addr, got);
        check_word(name, got, exp);
    endtask

    // one committing instr, redirect and result checked in the same cycle
    task automatic commit(input logic exc, input cp0_pkg::exc_code_t code, input logic in_bd,
                          input cp0_pkg::word_t at_pc, input cp0_pkg::word_t vaddr,
                          input logic is_eret, input logic exp_redir,
                          input cp0_pkg::word_t exp_res);
        valid     = 1'b1;
        exception = exc;
        exc_code  = code;
        bd        = in_bd;
        pc        = at_pc;
        bad_vaddr = vaddr;
        eret      = is_eret;
        @(negedge clk);
        check_word("redirect", {31'd0, redirect}, {31'd0, exp_redir});
        check_word("cp0_res", cp0_res, exp_res);
        step();
        drive_idle();
    endtask

    // plain instrs keep committing until an interrupt takes one
    task automatic wait_redirect(input cp0_pkg::word_t at_pc);
        int   n;
        logic hit;
        hit   = 1'b0;
        valid = 1'b1;
        pc    = at_pc;
        for (n = 0; n < TIMEOUT && !hit; n++) begin
            @(negedge clk);
            hit = redirect;
            if (hit) begin
                check_word("cp0_res", cp0_res, `CP0_EXC_VECTOR);
            end
            step();
        end
        drive_idle();
        assert (hit) else begin
            $display("%s: no redirect within %0d cycles", test_name, TIMEOUT);
            test_errs++;
        end
    endtask

    // poll cause until all given bits read as one
    task automatic wait_cause_set(input cp0_pkg::word_t bits);
        int             n;
        cp0_pkg::word_t got;
        got = '0;
        for (n = 0; n < TIMEOUT && (got & bits) != bits; n++) begin
            read_reg(`CP0_ADDR_CAUSE, got);
        end
        assert ((got & bits) == bits) else begin
            $display("%s: cause bits 0x%08h never came up", test_name, bits);
            test_errs++;
        end
    endtask

    // epc read first so the bound checker knows the target
    task automatic return_from_trap(input cp0_pkg::word_t exp_epc);
        check_reg("epc", `CP0_ADDR_EPC, exp_epc);
        commit(1'b0, '0, 1'b0, lcg_next(), '0, 1'b1, 1'b1, exp_epc);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            tests_passed++;
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errs);
        end
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        cp0_pkg::word_t w, c1, at_pc;
        lcg_state    = 32'h7e19_0cfd;
        tests_passed = 0;
        tests_failed = 0;
        ext_int      = '0;
        drive_idle();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("mtc0/mfc0 round trip");
        check_reg("status", `CP0_ADDR_STATUS, `CP0_STATUS_RESET);
        w = lcg_next();
        write_reg(`CP0_ADDR_STATUS, w);
        // im, exl, ie writable, bev stays
        check_reg("status", `CP0_ADDR_STATUS, `CP0_STATUS_RESET | (w & 32'h0000_ff03));
        write_reg(`CP0_ADDR_STATUS, '0);
        w = lcg_next();
        write_reg(`CP0_ADDR_EPC, w);
        check_reg("epc", `CP0_ADDR_EPC, w);
        w = lcg_next();
        write_reg(`CP0_ADDR_COMPARE, w);
        check_reg("compare", `CP0_ADDR_COMPARE, w);
        w = lcg_next();
        write_reg(`CP0_ADDR_CAUSE, w);
        check_reg("cause", `CP0_ADDR_CAUSE, cause_word(1'b0, 1'b0, {6'd0, w[9:8]}, '0));
        write_reg(`CP0_ADDR_CAUSE, '0);
        // compare zero keeps the timer quiet
        write_reg(`CP0_ADDR_COMPARE, '0);
        check_reg("prid", 8'h78, '0);
        check_reg("epc sel 1", 8'h71, '0);
        end_test();

        start_test("exception entry");
        trap_pc = lcg_next() & 32'hffff_fffc;
        commit(1'b1, 5'h0c, 1'b1, trap_pc, '0, 1'b0, 1'b1, `CP0_EXC_VECTOR);
        check_reg("epc", `CP0_ADDR_EPC, trap_pc - 32'd4);
        check_reg("cause", `CP0_ADDR_CAUSE, cause_word(1'b1, 1'b0, '0, 5'h0c));
        check_reg("status", `CP0_ADDR_STATUS, `CP0_STATUS_RESET | 32'h2);
        // nested, epc and bd hold
        commit(1'b1, 5'h0a, 1'b0, lcg_next(), '0, 1'b0, 1'b1, `CP0_EXC_VECTOR);
        check_reg("epc", `CP0_ADDR_EPC, trap_pc - 32'd4);
        check_reg("cause", `CP0_ADDR_CAUSE, cause_word(1'b1, 1'b0, '0, 5'h0a));
        end_test();

        start_test("eret");
        return_from_trap(trap_pc - 32'd4);
        check_reg("status", `CP0_ADDR_STATUS, `CP0_STATUS_RESET);
        end_test();

        start_test("address error");
        at_pc = lcg_next() & 32'hffff_fffc;
        w = lcg_next();
        commit(1'b1, `CP0_EXC_ADEL, 1'b0, at_pc, w, 1'b0, 1'b1, `CP0_EXC_VECTOR);
        check_reg("badvaddr", `CP0_ADDR_BADVADDR, w);
        w = lcg_next();
        commit(1'b1, `CP0_EXC_ADES, 1'b0, lcg_next(), w, 1'b0, 1'b1, `CP0_EXC_VECTOR);
        check_reg("badvaddr", `CP0_ADDR_BADVADDR, w);
        // other codes leave badvaddr alone
        commit(1'b1, 5'h0a, 1'b0, lcg_next(), lcg_next(), 1'b0, 1'b1, `CP0_EXC_VECTOR);
        check_reg("badvaddr", `CP0_ADDR_BADVADDR, w);
        return_from_trap(at_pc);
        end_test();

        start_test("timer");
        w = lcg_next() & 32'h00ff_fff0;
        write_reg(`CP0_ADDR_COUNT, w);
        check_reg("count", `CP0_ADDR_COUNT, w);
        // ten edges since reload by the next read, five ticks
        repeat (9) step();
        read_reg(`CP0_ADDR_COUNT, c1);
        check_word("count", c1, w + 32'd5);
        write_reg(`CP0_ADDR_COMPARE, c1 + 32'd3);
        wait_cause_set(32'h4000_8000);
        write_reg(`CP0_ADDR_STATUS, 32'h0000_8001);
        at_pc = lcg_next() & 32'hffff_fffc;
        commit(1'b0, '0, 1'b0, at_pc, '0, 1'b0, 1'b1, `CP0_EXC_VECTOR);
        check_reg("cause", `CP0_ADDR_CAUSE, cause_word(1'b0, 1'b1, 8'h80, `CP0_EXC_INT));
        // compare write acks ti
        write_reg(`CP0_ADDR_COMPARE, '0);
        check_reg("cause", `CP0_ADDR_CAUSE, cause_word(1'b0, 1'b0, '0, `CP0_EXC_INT));
        return_from_trap(at_pc);
        check_reg("status", `CP0_ADDR_STATUS, `CP0_STATUS_RESET | 32'h0000_8001);
        write_reg(`CP0_ADDR_STATUS, '0);
        end_test();

        start_test("external interrupt");
        // pin 2 lands in ip[4]
        ext_int = 6'b000100;
        wait_cause_set(32'h0000_1000);
        write_reg(`CP0_ADDR_STATUS, 32'h0000_0001);
        commit(1'b0, '0, 1'b0, lcg_next(), '0, 1'b0, 1'b0, '0);
        write_reg(`CP0_ADDR_STATUS, 32'h0000_1000);
        commit(1'b0, '0, 1'b0, lcg_next(), '0, 1'b0, 1'b0, '0);
        write_reg(`CP0_ADDR_STATUS, 32'h0000_1001);
        at_pc = lcg_next() & 32'hffff_fffc;
        wait_redirect(at_pc);
        check_reg("cause", `CP0_ADDR_CAUSE, cause_word(1'b0, 1'b0, 8'h10, `CP0_EXC_INT));
        ext_int = '0;
        return_from_trap(at_pc);
        write_reg(`CP0_ADDR_STATUS, '0);
        end_test();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: verif/cp0_props.sv
`include "cp0_cfg.svh"

module cp0_props (
    input logic               clk,
    input logic               rst,
    input logic               valid,
    input logic               exception,
    input logic               eret,
    input cp0_pkg::cp0_addr_t cp0_addr,
    input logic               redirect,
    input cp0_pkg::word_t     cp0_res
);

    // epc as last seen through an mfc0 read
    cp0_pkg::word_t seen_epc;

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_epc <= '0;
        end else if (!valid && cp0_addr == `CP0_ADDR_EPC) begin
            seen_epc <= cp0_res;
        end
    end

    // ------------------------------------------------------------
    // redirect rules
    // ------------------------------------------------------------

    redirect_in_reset: assert property (@(posedge clk) rst |-> !redirect)
        else $error("redirect high during reset");

    // traps always jump to the general vector
    trap_target: assert property (@(posedge clk) disable iff (rst)
        redirect && !eret |-> cp0_res == `CP0_EXC_VECTOR)
        else $error("trap redirect with target %08h", cp0_res);

    redirect_needs_valid: assert property (@(posedge clk) disable iff (rst)
        $rose(redirect) |-> valid)
        else $error("redirect rose without a valid instruction");

    // return goes back to the saved epc
    eret_target: assert property (@(posedge clk) disable iff (rst)
        redirect && eret && !exception |-> cp0_res == seen_epc)
        else $error("eret target %08h, epc read as %08h", cp0_res, seen_epc);

endmodule

bind cp0 cp0_props i_cp0_props (
    .clk(clk), .rst(rst), .valid(valid), .exception(exception), .eret(eret),
    .cp0_addr(cp0_addr), .redirect(redirect), .cp0_res(cp0_res)
);

// File: rtl/cp0.sv
`include "cp0_cfg.svh"

module cp0 (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid,
    input  logic               exception,
    input  logic               bd,
    input  logic               mtc0,
    input  logic               eret,
    input  cp0_pkg::exc_code_t exc_code,
    input  cp0_pkg::cp0_addr_t cp0_addr,
    input  cp0_pkg::word_t     pc,
    input  cp0_pkg::word_t     bad_vaddr,
    input  cp0_pkg::word_t     wdata,
    input  cp0_pkg::hw_int_t   ext_int,
    output logic               redirect,
    output cp0_pkg::word_t     cp0_res
);

    // commit control
    logic               take_exc;
    logic               take_eret;
    logic               wr_en;
    cp0_pkg::exc_code_t exc_code_eff;

    // register values
    cp0_pkg::word_t status;
    cp0_pkg::word_t cause;
    cp0_pkg::word_t epc;
    cp0_pkg::word_t count;
    cp0_pkg::word_t compare;
    cp0_pkg::word_t badvaddr;
    logic           timer_irq;
    logic           exl;

    // exl taken from the status word
    assign exl = status[`CP0_BIT_EXL];

    // ------------------------------------------------------------
    // commit decision and result
    // ------------------------------------------------------------

    cp0_commit i_commit (
        .valid(valid), .exception(exception), .eret(eret), .mtc0(mtc0),
        .exc_code(exc_code), .cp0_addr(cp0_addr),
        .status(status), .cause(cause), .epc(epc),
        .count(count), .compare(compare), .badvaddr(badvaddr),
        .take_exc(take_exc), .take_eret(take_eret), .wr_en(wr_en),
        .exc_code_eff(exc_code_eff), .redirect(redirect), .cp0_res(cp0_res)
    );

    // ------------------------------------------------------------
    // register blocks
    // ------------------------------------------------------------

    cp0_status i_status (
        .clk(clk), .rst(rst), .wr_en(wr_en), .take_exc(take_exc),
        .take_eret(take_eret), .cp0_addr(cp0_addr), .wdata(wdata),
        .status(status)
    );

    cp0_cause i_cause (
        .clk(clk), .rst(rst), .wr_en(wr_en), .take_exc(take_exc), .bd(bd),
        .timer_irq(timer_irq), .exl(exl), .ext_int(ext_int),
        .exc_code_eff(exc_code_eff), .cp0_addr(cp0_addr), .wdata(wdata),
        .cause(cause)
    );

    cp0_timer i_timer (
        .clk(clk), .rst(rst), .wr_en(wr_en), .cp0_addr(cp0_addr), .wdata(wdata),
        .count(count), .compare(compare), .timer_irq(timer_irq)
    );

    cp0_fault_addr i_fault_addr (
        .clk(clk), .rst(rst), .wr_en(wr_en), .take_exc(take_exc), .bd(bd),
        .exl(exl), .exc_code_eff(exc_code_eff), .cp0_addr(cp0_addr),
        .pc(pc), .bad_vaddr(bad_vaddr), .wdata(wdata),
        .epc(epc), .badvaddr(badvaddr)
    );

endmodule

// File: rtl/cp0_fault_addr.sv
`include "cp0_cfg.svh"

module cp0_fault_addr (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  logic               take_exc,
    input  logic               bd,
    input  logic               exl,
    input  cp0_pkg::exc_code_t exc_code_eff,
    input  cp0_pkg::cp0_addr_t cp0_addr,
    input  cp0_pkg::word_t     pc,
    input  cp0_pkg::word_t     bad_vaddr,
    input  cp0_pkg::word_t     wdata,
    output cp0_pkg::word_t     epc,
    output cp0_pkg::word_t     badvaddr
);

    logic           epc_sel;
    logic           addr_err;
    cp0_pkg::word_t restart_pc;

    assign epc_sel = wr_en && (cp0_addr == `CP0_ADDR_EPC);

    // delay slot restarts at the branch
    assign restart_pc = bd ? (pc - 32'd4) : pc;

    // adel or ades
    assign addr_err = (exc_code_eff == `CP0_EXC_ADEL) || (exc_code_eff == `CP0_EXC_ADES);

    // ------------------------------------------------------------
    // epc
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (take_exc) begin
            // first-level trap only, nested keeps epc
            if (!exl) begin
                epc <= restart_pc;
            end
        end else if (epc_sel) begin
            epc <= wdata;
        end
    end

    // ------------------------------------------------------------
    // badvaddr
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            badvaddr <= '0;
        end else if (take_exc && addr_err) begin
            badvaddr <= bad_vaddr;
        end
    end

endmodule

// File: rtl/cp0_timer.sv
`include "cp0_cfg.svh"

module cp0_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  cp0_pkg::cp0_addr_t cp0_addr,
    input  cp0_pkg::word_t     wdata,
    output cp0_pkg::word_t     count,
    output cp0_pkg::word_t     compare,
    output logic               timer_irq
);

    logic phase;
    logic count_sel;
    logic compare_sel;
    logic match;

    assign count_sel   = wr_en && (cp0_addr == `CP0_ADDR_COUNT);
    assign compare_sel = wr_en && (cp0_addr == `CP0_ADDR_COMPARE);

    // zero compare means timer off
    assign match = (compare != '0) && (count == compare);

    // ------------------------------------------------------------
    // count at half core clock
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            phase <= 1'b0;
        end else if (count_sel) begin
            // reload, phase restarts
            count <= wdata;
            phase <= 1'b0;
        end else begin
            phase <= ~phase;
            if (phase) begin
                count <= count + 32'd1;
            end
        end
    end

    // ------------------------------------------------------------
    // compare and timer interrupt
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            compare   <= '0;
            timer_irq <= 1'b0;
        end else if (compare_sel) begin
            // writing compare acks the interrupt
            compare   <= wdata;
            timer_irq <= 1'b0;
        end else if (match) begin
            timer_irq <= 1'b1;
        end
    end

endmodule

// File: rtl/cp0_cause.sv
`include "cp0_cfg.svh"

module cp0_cause (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  logic               take_exc,
    input  logic               bd,
    input  logic               timer_irq,
    input  logic               exl,
    input  cp0_pkg::hw_int_t   ext_int,
    input  cp0_pkg::exc_code_t exc_code_eff,
    input  cp0_pkg::cp0_addr_t cp0_addr,
    input  cp0_pkg::word_t     wdata,
    output cp0_pkg::word_t     cause
);

    cp0_pkg::hw_int_t   ext_int_q;
    logic [1:0]         ip_sw;
    cp0_pkg::int_mask_t ip;
    cp0_pkg::exc_code_t exc_q;
    logic               bd_q;
    logic               sel;

    assign sel = wr_en && (cp0_addr == `CP0_ADDR_CAUSE);

    // ------------------------------------------------------------
    // interrupt pending field
    // ------------------------------------------------------------

    // pins sampled once, one cycle of latency
    always_ff @(posedge clk) begin
        if (rst) begin
            ext_int_q <= '0;
        end else begin
            ext_int_q <= ext_int;
        end
    end

    // ip[7] shared between pin 5 and the timer
    assign ip = {ext_int_q[5] | timer_irq, ext_int_q[4:0], ip_sw};

    // ------------------------------------------------------------
    // software ip, exccode, bd
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            ip_sw <= '0;
            exc_q <= '0;
            bd_q  <= 1'b0;
        end else begin
            // only the two software bits are writable
            if (sel) begin
                ip_sw <= wdata[`CP0_IP_LSB +: 2];
            end
            if (take_exc) begin
                exc_q <= exc_code_eff;
                // nested trap keeps the first bd
                if (!exl) begin
                    bd_q <= bd;
                end
            end
        end
    end

    always_comb begin
        cause = '0;
        cause[`CP0_BIT_BD] = bd_q;
        cause[`CP0_BIT_TI] = timer_irq;
        cause[`CP0_IP_LSB +: 8] = ip;
        cause[`CP0_EXC_LSB +: 5] = exc_q;
    end

endmodule

// File: rtl/cp0_status.sv
`include "cp0_cfg.svh"

module cp0_status (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  logic               take_exc,
    input  logic               take_eret,
    input  cp0_pkg::cp0_addr_t cp0_addr,
    input  cp0_pkg::word_t     wdata,
    output cp0_pkg::word_t     status
);

    cp0_pkg::int_mask_t im;
    logic               exl;
    logic               ie;
    logic               sel;

    assign sel = wr_en && (cp0_addr == `CP0_ADDR_STATUS);

    // ------------------------------------------------------------
    // writable fields
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            im  <= '0;
            exl <= 1'b0;
            ie  <= 1'b0;
        end else begin
            // mtc0 touches im, exl and ie only
            if (sel) begin
                im  <= wdata[`CP0_IM_LSB +: 8];
                exl <= wdata[`CP0_BIT_EXL];
                ie  <= wdata[`CP0_BIT_IE];
            end
            // trap entry / return override exl
            if (take_exc) begin
                exl <= 1'b1;
            end else if (take_eret) begin
                exl <= 1'b0;
            end
        end
    end

    // assemble the word, bev and other fixed bits from reset value
    always_comb begin
        status = `CP0_STATUS_RESET;
        status[`CP0_IM_LSB +: 8] = im;
        status[`CP0_BIT_EXL] = exl;
        status[`CP0_BIT_IE] = ie;
    end

endmodule

// File: rtl/cp0_commit.sv
`include "cp0_cfg.svh"

module cp0_commit (
    input  logic              valid,
    input  logic              exception,
    input  logic              eret,
    input  logic              mtc0,
    input  cp0_pkg::exc_code_t exc_code,
    input  cp0_pkg::cp0_addr_t cp0_addr,
    input  cp0_pkg::word_t    status,
    input  cp0_pkg::word_t    cause,
    input  cp0_pkg::word_t    epc,
    input  cp0_pkg::word_t    count,
    input  cp0_pkg::word_t    compare,
    input  cp0_pkg::word_t    badvaddr,
    output logic              take_exc,
    output logic              take_eret,
    output logic              wr_en,
    output cp0_pkg::exc_code_t exc_code_eff,
    output logic              redirect,
    output cp0_pkg::word_t    cp0_res
);

    cp0_pkg::int_mask_t int_hit;
    logic               int_pending;
    cp0_pkg::word_t     rd_data;

    // ------------------------------------------------------------
    // interrupt detection
    // ------------------------------------------------------------

    // pending bits that are also unmasked
    assign int_hit = cause[`CP0_IP_LSB +: 8] & status[`CP0_IM_LSB +: 8];

    // global enable, not already inside a handler
    assign int_pending = (|int_hit) && status[`CP0_BIT_IE] && !status[`CP0_BIT_EXL];

    // ------------------------------------------------------------
    // trap / return / write decision
    // ------------------------------------------------------------

    // pending interrupt turns the committing instr into a trap
    assign take_exc = valid && (exception || int_pending);

    // interrupt wins over the instruction's own code
    assign exc_code_eff = int_pending ? `CP0_EXC_INT : exc_code;

    // eret only when nothing traps in the same cycle
    assign take_eret = valid && eret && !take_exc;

    // a trapping mtc0 must not write
    assign wr_en = valid && mtc0 && !take_exc;

    // clear pipe, stop writes, jump
    assign redirect = take_exc || take_eret;

    // ------------------------------------------------------------
    // mfc0 read mux
    // ------------------------------------------------------------

    always_comb begin
        case (cp0_addr)
            `CP0_ADDR_STATUS:   rd_data = status;
            `CP0_ADDR_CAUSE:    rd_data = cause;
            `CP0_ADDR_EPC:      rd_data = epc;
            `CP0_ADDR_COUNT:    rd_data = count;
            `CP0_ADDR_COMPARE:  rd_data = compare;
            `CP0_ADDR_BADVADDR: rd_data = badvaddr;
            // unimplemented regs and selects
            default:            rd_data = '0;
        endcase
    end

    // result word
    // jump target while redirecting, read data otherwise
    always_comb begin
        if (take_exc) begin
            cp0_res = `CP0_EXC_VECTOR;
        end else if (take_eret) begin
            cp0_res = epc;
        end else begin
            cp0_res = rd_data;
        end
    end

endmodule

// File: rtl/cp0_pkg.sv
package cp0_pkg;

    // ------------------------------------------------------------
    // shared vector types for the cp0 block
    // ------------------------------------------------------------

    // full data word
    // pc, register contents, mfc0 result, jump target
    typedef logic [31:0] word_t;

    // cp0 register address as carried down the pipe
    // upper 5 bits register number, lower 3 bits select
    typedef logic [7:0] cp0_addr_t;

    // exception code as stored in cause.exccode
    typedef logic [4:0] exc_code_t;

    // external hardware interrupt pins
    // map onto cause.ip[7:2]
    typedef logic [5:0] hw_int_t;

    // interrupt pending / mask field
    // same layout for cause.ip and status.im
    typedef logic [7:0] int_mask_t;

endpackage

// File: rtl/cp0_cfg.svh
`ifndef CP0_CFG_SVH
`define CP0_CFG_SVH

// ------------------------------------------------------------
// register addresses
// ------------------------------------------------------------

// encoded as {reg[4:0], sel[2:0]}, sel 0 only
`define CP0_ADDR_BADVADDR 8'h40
`define CP0_ADDR_COUNT 8'h48
`define CP0_ADDR_COMPARE 8'h58
`define CP0_ADDR_STATUS 8'h60
`define CP0_ADDR_CAUSE 8'h68
`define CP0_ADDR_EPC 8'h70

// ------------------------------------------------------------
// field positions
// ------------------------------------------------------------

// status
`define CP0_BIT_IE 0
`define CP0_BIT_EXL 1
`define CP0_IM_LSB 8

// cause
`define CP0_BIT_BD 31
`define CP0_BIT_TI 30
`define CP0_IP_LSB 8
`define CP0_EXC_LSB 2

// ------------------------------------------------------------
// exception codes and vector
// ------------------------------------------------------------

`define CP0_EXC_INT 5'h00
`define CP0_EXC_ADEL 5'h04
`define CP0_EXC_ADES 5'h05

// single general vector with bev set
`define CP0_EXC_VECTOR 32'hbfc0_0380

// status after reset, only bev set
`define CP0_STATUS_RESET 32'h0040_0000

`endif
